// ==== mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// word width of datapath, registers and memory port
`define DATA_WIDTH 32

// architectural registers, r0 included
`define REG_COUNT 32

// depth of the unified instruction and data memory, in words
`define MEM_WORDS 256

// address of the first fetch after reset
`define RESET_VECTOR 0

`endif

// ==== isaPkg.sv ====
`default_nettype none

package isaPkg;

	//////////////////////////////
	// opcode and funct encodings
	//////////////////////////////

	// primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// funct field of r-type, bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// instruction word split into its fields
	// immediate shares the low 16 bits (rd, shamt, funct)
	typedef struct packed {
		opcodeT     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT      funct;
	} instrFieldsT;

	// alu operation select
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluOpT;

endpackage

`default_nettype wire

// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	// fsm states of the multicycle controller
	typedef enum logic [3:0] {
		fetch         = 4'd0,
		decode        = 4'd1,
		memAddr       = 4'd2,
		memRead       = 4'd3,
		memWriteback  = 4'd4,
		memStore      = 4'd5,
		execute       = 4'd6,
		aluWriteback  = 4'd7,
		branch        = 4'd8,
		addiExecute   = 4'd9,
		addiWriteback = 4'd10
	} stateT;

	// what the alu decoder should do with funct
	typedef enum logic [1:0] {
		clsAdd   = 2'b00,
		clsSub   = 2'b01,
		clsFunct = 2'b10
	} aluClassT;

	// alu operand b select
	localparam logic [1:0] srcBReg      = 2'd0;
	localparam logic [1:0] srcBFour     = 2'd1;
	localparam logic [1:0] srcBImm      = 2'd2;
	localparam logic [1:0] srcBImmShift = 2'd3;

	// all datapath controls of one state
	typedef struct packed {
		logic          iorD;
		logic          aluSrcA;
		logic [1:0]    aluSrcB;
		logic          memToReg;
		logic          regDst;
		logic          irWrite;
		logic          memWrite;
		logic          pcWrite;
		logic          branch;
		logic          regWrite;
		isaPkg::aluOpT aluOp;
	} ctrlWordT;

endpackage

`default_nettype wire

// ==== aluDecoder.sv ====
`default_nettype none

module aluDecoder (
	input  ctrlPkg::aluClassT aluClass,
	input  isaPkg::functT     funct,
	output isaPkg::aluOpT     aluOp
);

	always_comb begin
		case (aluClass)
			// address and pc arithmetic
			ctrlPkg::clsAdd: aluOp = isaPkg::aluAdd;
			// beq compares by subtraction
			ctrlPkg::clsSub: aluOp = isaPkg::aluSub;
			ctrlPkg::clsFunct: begin
				// r-type, look at funct
				case (funct)
					isaPkg::fnAdd: aluOp = isaPkg::aluAdd;
					isaPkg::fnSub: aluOp = isaPkg::aluSub;
					isaPkg::fnAnd: aluOp = isaPkg::aluAnd;
					isaPkg::fnOr:  aluOp = isaPkg::aluOr;
					isaPkg::fnSlt: aluOp = isaPkg::aluSlt;
					// unsupported funct falls back to add
					default:       aluOp = isaPkg::aluAdd;
				endcase
			end
			default: aluOp = isaPkg::aluAdd;
		endcase
	end

endmodule

`default_nettype wire

// ==== mipsController.sv ====
`default_nettype none

module mipsController (
	input  logic                clk,
	input  logic                rst,
	input  isaPkg::instrFieldsT instr,
	output ctrlPkg::ctrlWordT   ctrl,
	output logic                instrStart
);

	ctrlPkg::stateT   state;
	ctrlPkg::stateT   nextState;
	ctrlPkg::aluClassT aluClass;
	isaPkg::aluOpT    decodedOp;

	aluDecoder aluDecoder_i (
		.aluClass(aluClass),
		.funct(instr.funct),
		.aluOp(decodedOp)
	);

	//////////////////////////////
	// state register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ctrlPkg::fetch;
		end else begin
			state <= nextState;
		end
	end

	// every instruction starts with a fetch
	assign instrStart = (state == ctrlPkg::fetch);

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		nextState = ctrlPkg::fetch;
		case (state)
			ctrlPkg::fetch: nextState = ctrlPkg::decode;
			ctrlPkg::decode: begin
				// dispatch on opcode, unknown ones go back to fetch
				case (instr.opcode)
					isaPkg::opLw:    nextState = ctrlPkg::memAddr;
					isaPkg::opSw:    nextState = ctrlPkg::memAddr;
					isaPkg::opRType: nextState = ctrlPkg::execute;
					isaPkg::opBeq:   nextState = ctrlPkg::branch;
					isaPkg::opAddi:  nextState = ctrlPkg::addiExecute;
					default:         nextState = ctrlPkg::fetch;
				endcase
			end
			ctrlPkg::memAddr: begin
				// lw reads, sw stores
				if (instr.opcode == isaPkg::opLw) begin
					nextState = ctrlPkg::memRead;
				end else begin
					nextState = ctrlPkg::memStore;
				end
			end
			ctrlPkg::memRead:     nextState = ctrlPkg::memWriteback;
			ctrlPkg::execute:     nextState = ctrlPkg::aluWriteback;
			ctrlPkg::addiExecute: nextState = ctrlPkg::addiWriteback;
			// writeback, store and branch states all end the instruction
			default:              nextState = ctrlPkg::fetch;
		endcase
	end

	//////////////////////////////
	// moore outputs
	//////////////////////////////

	// alu class per state
	always_comb begin
		case (state)
			ctrlPkg::execute: aluClass = ctrlPkg::clsFunct;
			ctrlPkg::branch:  aluClass = ctrlPkg::clsSub;
			default:          aluClass = ctrlPkg::clsAdd;
		endcase
	end

	always_comb begin
		// idle word, no enables
		ctrl = '0;
		case (state)
			ctrlPkg::fetch: begin
				// ir <= mem[pc], pc <= pc + 4
				ctrl.aluSrcB = ctrlPkg::srcBFour;
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
			end
			// branch target into aluOut while registers are read
			ctrlPkg::decode: ctrl.aluSrcB = ctrlPkg::srcBImmShift;
			ctrlPkg::memAddr, ctrlPkg::addiExecute: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = ctrlPkg::srcBImm;
			end
			ctrlPkg::memRead: ctrl.iorD = 1'b1;
			ctrlPkg::memWriteback: begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			ctrlPkg::memStore: begin
				ctrl.iorD     = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			ctrlPkg::execute: ctrl.aluSrcA = 1'b1;
			ctrlPkg::aluWriteback: begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			ctrlPkg::branch: begin
				// a - b, pc taken from aluOut on zero
				ctrl.aluSrcA = 1'b1;
				ctrl.branch  = 1'b1;
			end
			// rt gets the alu result
			ctrlPkg::addiWriteback: ctrl.regWrite = 1'b1;
			default: ctrl = '0;
		endcase
		ctrl.aluOp = decodedOp;
	end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none
`include "mips_settings.svh"

module regFile (
	input  logic                   clk,
	input  logic [4:0]             readAddrA,
	input  logic [4:0]             readAddrB,
	output logic [`DATA_WIDTH-1:0] readDataA,
	output logic [`DATA_WIDTH-1:0] readDataB,
	input  logic                   writeEnable,
	input  logic [4:0]             writeAddr,
	input  logic [`DATA_WIDTH-1:0] writeData
);

	logic [`DATA_WIDTH-1:0] regs [0:`REG_COUNT-1];

	// single write port, r0 never written
	always_ff @(posedge clk) begin
		if (writeEnable && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// combinational reads
	// r0 is hard zero
	assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== mipsDatapath.sv ====
`default_nettype none
`include "mips_settings.svh"

module mipsDatapath (
	input  logic                   clk,
	input  logic                   rst,
	input  ctrlPkg::ctrlWordT      ctrl,
	output isaPkg::instrFieldsT    instr,
	output logic [`DATA_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memWriteData,
	input  logic [`DATA_WIDTH-1:0] memReadData,
	output logic [4:0]             regReadAddrA,
	output logic [4:0]             regReadAddrB,
	output logic [4:0]             regWriteAddr,
	input  logic [`DATA_WIDTH-1:0] regReadDataA,
	input  logic [`DATA_WIDTH-1:0] regReadDataB,
	output logic [`DATA_WIDTH-1:0] regWriteData
);

	logic [`DATA_WIDTH-1:0] pc;
	isaPkg::instrFieldsT    instrReg;
	logic [`DATA_WIDTH-1:0] dataReg;
	logic [`DATA_WIDTH-1:0] aReg;
	logic [`DATA_WIDTH-1:0] bReg;
	logic [`DATA_WIDTH-1:0] aluOut;

	logic [`DATA_WIDTH-1:0] immExt;
	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic                   zero;
	logic [`DATA_WIDTH-1:0] pcNext;
	logic                   pcEnable;

	//////////////////////////////
	// state registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= `RESET_VECTOR;
			instrReg <= '0;
			dataReg  <= '0;
			aReg     <= '0;
			bReg     <= '0;
			aluOut   <= '0;
		end else begin
			if (pcEnable) begin
				pc <= pcNext;
			end
			// ir only loads in fetch
			if (ctrl.irWrite) begin
				instrReg <= memReadData;
			end
			// scratch registers load every cycle
			dataReg <= memReadData;
			aReg    <= regReadDataA;
			bReg    <= regReadDataB;
			aluOut  <= aluResult;
		end
	end

	// sign-extended 16-bit immediate
	assign immExt = {{(`DATA_WIDTH-16){instrReg[15]}}, instrReg[15:0]};

	//////////////////////////////
	// alu and operand muxes
	//////////////////////////////

	assign srcA = ctrl.aluSrcA ? aReg : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			ctrlPkg::srcBReg:  srcB = bReg;
			ctrlPkg::srcBFour: srcB = `DATA_WIDTH'(4);
			ctrlPkg::srcBImm:  srcB = immExt;
			// word offset for branches
			default:           srcB = immExt << 2;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			isaPkg::aluSub: aluResult = srcA - srcB;
			isaPkg::aluAnd: aluResult = srcA & srcB;
			isaPkg::aluOr:  aluResult = srcA | srcB;
			// signed less-than, result in bit 0
			isaPkg::aluSlt: aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default:        aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0);

	// pc update
	// branch target was left in aluOut by decode
	assign pcNext   = ctrl.branch ? aluOut : aluResult;
	assign pcEnable = ctrl.pcWrite | (ctrl.branch & zero);

	//////////////////////////////
	// memory and register file
	//////////////////////////////

	assign memAddr      = ctrl.iorD ? aluOut : pc;
	assign memWriteData = bReg;
	assign instr        = instrReg;

	assign regReadAddrA = instrReg.rs;
	assign regReadAddrB = instrReg.rt;
	// rd for r-type, rt for lw and addi
	assign regWriteAddr = ctrl.regDst ? instrReg.rd : instrReg.rt;
	assign regWriteData = ctrl.memToReg ? dataReg : aluOut;

endmodule

`default_nettype wire

// ==== mipsTop.sv ====
`default_nettype none
`include "mips_settings.svh"

module mipsTop (
	input  logic                   clk,
	input  logic                   rst,
	output logic [`DATA_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memWriteData,
	output logic                   memWrite,
	input  logic [`DATA_WIDTH-1:0] memReadData,
	output logic                   instrStart
);

	ctrlPkg::ctrlWordT      ctrl;
	isaPkg::instrFieldsT    instr;
	logic [4:0]             regReadAddrA;
	logic [4:0]             regReadAddrB;
	logic [4:0]             regWriteAddr;
	logic [`DATA_WIDTH-1:0] regReadDataA;
	logic [`DATA_WIDTH-1:0] regReadDataB;
	logic [`DATA_WIDTH-1:0] regWriteData;

	// fsm, moore controls
	mipsController controller_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.ctrl(ctrl),
		.instrStart(instrStart)
	);

	mipsDatapath datapath_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.instr(instr),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.regReadAddrA(regReadAddrA),
		.regReadAddrB(regReadAddrB),
		.regWriteAddr(regWriteAddr),
		.regReadDataA(regReadDataA),
		.regReadDataB(regReadDataB),
		.regWriteData(regWriteData)
	);

	// write enable straight from the control word
	regFile regFile_i (
		.clk(clk),
		.readAddrA(regReadAddrA),
		.readAddrB(regReadAddrB),
		.readDataA(regReadDataA),
		.readDataB(regReadDataB),
		.writeEnable(ctrl.regWrite),
		.writeAddr(regWriteAddr),
		.writeData(regWriteData)
	);

	// memory write strobe of the store state
	assign memWrite = ctrl.memWrite;

endmodule

`default_nettype wire

// ==== mipsTb.sv ====
`default_nettype none
`include "mips_settings.svh"

module mipsTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int addrBits = $clog2(`MEM_WORDS);
	// base register points into the middle of the data area
	localparam logic [31:0] dataBase = 32'h380;

	// expected effect of one instruction
	typedef struct packed {
		logic [31:0] nextPc;
		logic        isStore;
		logic [31:0] storeAddr;
		logic [31:0] storeData;
		int          cycles;
	} refResultT;

	logic                   clk;
	logic                   rst;
	logic [`DATA_WIDTH-1:0] memAddr;
	logic [`DATA_WIDTH-1:0] memWriteData;
	logic                   memWrite;
	logic [`DATA_WIDTH-1:0] memReadData;
	logic                   instrStart;

	logic [31:0] mem [0:`MEM_WORDS-1];
	logic [31:0] refMem [0:`MEM_WORDS-1];
	logic [31:0] refRegs [0:`REG_COUNT-1];
	// test id of each code word as 1 r-type, 2 load/store, 3 addi or 4 branch
	int          wordClass [0:`MEM_WORDS-1];
	int          checks [0:5];
	int          fails [0:5];
	logic [31:0] lcgState;
	int          codeWords;
	logic [31:0] haltAddr;
	logic        programReady;

	mipsTop dut_i (
		.clk(clk),
		.rst(rst),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite),
		.memReadData(memReadData),
		.instrStart(instrStart)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// unified memory model
	//////////////////////////////

	// same-cycle read
	assign memReadData = mem[memAddr[addrBits+1:2]];

	always @(posedge clk) begin
		if (memWrite) begin
			mem[memAddr[addrBits+1:2]] <= memWriteData;
		end
	end

	// lcg step returning upper bits modulo n
	function automatic int unsigned pick(input int unsigned n);
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return (lcgState >> 8) % n;
	endfunction

	function automatic logic [31:0] encR(input isaPkg::functT fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {isaPkg::opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input isaPkg::opcodeT op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [4:0] anyReg();
		return 5'(pick(32));
	endfunction

	// r1 holds the data base and is never a destination
	function automatic logic [4:0] destReg();
		logic [4:0] r;
		r = 5'(pick(32));
		if (r == 5'd1) begin
			r = 5'd2;
		end
		return r;
	endfunction

	// byte offset from -128 to +124 around the base
	function automatic logic [15:0] dataOffset();
		return 16'((int'(pick(64)) - 32) * 4);
	endfunction

	task automatic emit(input logic [31:0] word, input int cls);
		mem[codeWords] = word;
		wordClass[codeWords] = cls;
		codeWords++;
	endtask

	//////////////////////////////
	// program builder
	//////////////////////////////

	task automatic buildProgram();
		isaPkg::functT fnList [0:4];
		logic [4:0]    rd;
		logic [4:0]    rs;
		logic [15:0]   imm;
		fnList = '{isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnSlt};
		// recognizable fill that differs in every word
		for (int i = 0; i < `MEM_WORDS; i++) begin
			mem[i] = 32'hc0de0000 | i;
			wordClass[i] = 4;
		end
		codeWords = 0;
		// define every register before any read
		emit(encI(isaPkg::opAddi, 5'd1, 5'd0, dataBase[15:0]), 3);
		for (int r = 2; r < `REG_COUNT; r++) begin
			emit(encI(isaPkg::opAddi, 5'(r), 5'd0, 16'(pick(65536))), 3);
		end
		for (int b = 0; b < 36; b++) begin
			case (pick(4))
				0: begin
					// r-type whose result is stored with r0 as target now and then
					rd = (pick(6) == 0) ? 5'd0 : destReg();
					emit(encR(fnList[pick(5)], rd, anyReg(), anyReg()), 1);
					emit(encI(isaPkg::opSw, rd, 5'd1, dataOffset()), 1);
				end
				1: begin
					rd = destReg();
					imm = (pick(2) == 0) ? 16'(int'(pick(256)) - 128) : 16'(pick(65536));
					emit(encI(isaPkg::opAddi, rd, anyReg(), imm), 3);
					emit(encI(isaPkg::opSw, rd, 5'd1, dataOffset()), 3);
				end
				2: begin
					// store then load back and store the loaded value elsewhere
					rd = destReg();
					imm = dataOffset();
					emit(encI(isaPkg::opSw, anyReg(), 5'd1, imm), 2);
					emit(encI(isaPkg::opLw, rd, 5'd1, imm), 2);
					emit(encI(isaPkg::opSw, rd, 5'd1, dataOffset()), 2);
				end
				default: begin
					// half of the branches compare a register with itself
					rs = anyReg();
					rd = (pick(2) == 0) ? rs : anyReg();
					emit(encI(isaPkg::opBeq, rd, rs, 16'd1), 4);
					// unknown opcode that runs only when the branch is not taken
					emit({6'h3f, 26'(pick(1 << 26))}, 4);
				end
			endcase
		end
		// branch to itself ends the program
		haltAddr = 32'(codeWords * 4);
		emit(encI(isaPkg::opBeq, 5'd0, 5'd0, 16'hffff), 4);
		for (int i = 0; i < `MEM_WORDS; i++) begin
			refMem[i] = mem[i];
		end
		for (int r = 0; r < `REG_COUNT; r++) begin
			refRegs[r] = '0;
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic refResultT refStep(input logic [31:0] pc);
		refResultT           r;
		isaPkg::instrFieldsT f;
		logic [31:0]         word;
		logic [31:0]         a;
		logic [31:0]         b;
		logic [31:0]         imm;
		logic [31:0]         addr;
		logic [31:0]         res;
		word = refMem[pc[addrBits+1:2]];
		f = word;
		a = refRegs[f.rs];
		b = refRegs[f.rt];
		imm = {{16{word[15]}}, word[15:0]};
		addr = a + imm;
		r = '0;
		r.nextPc = pc + 32'd4;
		case (f.opcode)
			isaPkg::opRType: begin
				r.cycles = 4;
				case (f.funct)
					isaPkg::fnSub: res = a - b;
					isaPkg::fnAnd: res = a & b;
					isaPkg::fnOr:  res = a | b;
					isaPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:       res = a + b;
				endcase
				if (f.rd != 5'd0) begin
					refRegs[f.rd] = res;
				end
			end
			isaPkg::opLw: begin
				r.cycles = 5;
				if (f.rt != 5'd0) begin
					refRegs[f.rt] = refMem[addr[addrBits+1:2]];
				end
			end
			isaPkg::opSw: begin
				r.cycles = 4;
				refMem[addr[addrBits+1:2]] = b;
				r.isStore = 1'b1;
				r.storeAddr = addr;
				r.storeData = b;
			end
			isaPkg::opBeq: begin
				r.cycles = 3;
				if (a == b) begin
					r.nextPc = pc + 32'd4 + (imm << 2);
				end
			end
			isaPkg::opAddi: begin
				r.cycles = 4;
				if (f.rt != 5'd0) begin
					refRegs[f.rt] = a + imm;
				end
			end
			default: r.cycles = 2;
		endcase
		return r;
	endfunction

	function automatic string testName(input int id);
		case (id)
			0:       return "reset";
			1:       return "r-type";
			2:       return "load/store";
			3:       return "addi";
			4:       return "branch";
			default: return "cycle counts";
		endcase
	endfunction

	task automatic logError(input int id, input string msg);
		$display("FAIL %0d ns: %s", $time, msg);
		fails[id]++;
	endtask

	task automatic printSummary(input int id);
		$display("test %s done: %0d checks, %0d errors", testName(id), checks[id], fails[id]);
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin : stimulus
		clk = 1'b0;
		rst = 1'b1;
		programReady = 1'b0;
		lcgState = 32'hdb55;
		for (int t = 0; t < 6; t++) begin
			checks[t] = 0;
			fails[t] = 0;
		end
		buildProgram();
		programReady = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

	//////////////////////////////
	// comparison
	//////////////////////////////

	// samples at the rising edge before any register moves
	initial begin : compare
		refResultT   res;
		logic [31:0] refPc;
		logic [31:0] prevPc;
		logic [31:0] seenAddr;
		logic [31:0] seenData;
		logic        seenStore;
		logic        started;
		logic        done;
		int          cycleCount;
		int          prevClass;
		int          haltRuns;
		int          totalChecks;
		int          totalFails;
		res = '0;
		refPc = `RESET_VECTOR;
		prevPc = '0;
		seenAddr = '0;
		seenData = '0;
		seenStore = 1'b0;
		started = 1'b0;
		done = 1'b0;
		cycleCount = 0;
		prevClass = 0;
		haltRuns = 0;
		@(posedge clk);
		while (rst) begin
			checks[0]++;
			if (memWrite !== 1'b0) begin
				logError(0, "memWrite high while reset is held");
			end
			@(posedge clk);
		end
		while (!done) begin
			cycleCount++;
			if (memWrite === 1'b1) begin
				seenStore = 1'b1;
				seenAddr = memAddr;
				seenData = memWriteData;
			end
			if (instrStart === 1'b1) begin
				if (!started) begin
					checks[0]++;
					if (memAddr !== `RESET_VECTOR) begin
						logError(0, $sformatf("first fetch from %h", memAddr));
					end
					printSummary(0);
					started = 1'b1;
				end else begin
					// close the previous instruction
					checks[5]++;
					if (cycleCount - 1 != res.cycles) begin
						logError(5, $sformatf("pc %h took %0d cycles, expected %0d",
							prevPc, cycleCount - 1, res.cycles));
					end
					checks[prevClass]++;
					if (seenStore !== res.isStore) begin
						logError(prevClass, $sformatf("pc %h store seen %0d, expected %0d",
							prevPc, seenStore, res.isStore));
					end
					checks[prevClass]++;
					if (res.isStore && (seenAddr !== res.storeAddr ||
						seenData !== res.storeData)) begin
						logError(prevClass,
							$sformatf("pc %h stored %h at %h, expected %h at %h",
							prevPc, seenData, seenAddr, res.storeData, res.storeAddr));
					end
					checks[prevClass]++;
					if (memAddr !== res.nextPc) begin
						logError(prevClass, $sformatf("fetch from %h after pc %h, expected %h",
							memAddr, prevPc, res.nextPc));
					end
				end
				if (haltRuns == 2) begin
					done = 1'b1;
				end else begin
					prevPc = refPc;
					prevClass = wordClass[refPc[addrBits+1:2]];
					if (refPc == haltAddr) begin
						haltRuns++;
					end
					res = refStep(refPc);
					refPc = res.nextPc;
					cycleCount = 1;
					seenStore = 1'b0;
				end
			end
			if (!done) begin
				@(posedge clk);
			end
		end
		for (int t = 1; t < 6; t++) begin
			printSummary(t);
		end
		totalChecks = 0;
		totalFails = 0;
		for (int t = 0; t < 6; t++) begin
			totalChecks += checks[t];
			totalFails += fails[t];
		end
		$display("total: %0d checks, %0d errors", totalChecks, totalFails);
		if (totalFails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// five cycles for each word and two extra halts plus reset and slack
	initial begin : watchdog
		int limit;
		wait (programReady === 1'b1);
		limit = (codeWords + 2) * 5 * 20 + 10 * 20 + 1000;
		#(limit);
		$display("timeout: the program did not reach its end within %0d ns", limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
isaPkg.sv
ctrlPkg.sv
aluDecoder.sv
mipsController.sv
regFile.sv
mipsDatapath.sv
mipsTop.sv
mipsTb.sv

// ==== Makefile ====
# Verilator build and run of the multicycle core testbench
SOURCES := $(shell grep -v '^+' build.f) mips_settings.svh

.PHONY: all run clean

all: obj_dir/mipsTb

# rebuilt only when a source or the file list changes
obj_dir/mipsTb: build.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module mipsTb -f build.f -o mipsTb

# the log decides pass or fail
run: obj_dir/mipsTb
	./obj_dir/mipsTb | tee sim.log
	grep -qx '=== PASS ===' sim.log

clean:
	rm -rf obj_dir sim.log
